//--- src/csr_defines.svh
`ifndef CSR_DEFINES_SVH
`define CSR_DEFINES_SVH

// Machine information registers
// Vendor, implementation and hart ID are left at zero
`define CSR_MVENDORID 32'h0000_0000
`define CSR_MARCHID 32'h0000_0001
`define CSR_MIMPID 32'h0000_0000
`define CSR_MHARTID 32'h0000_0000

// Trap setup constants

// MXL = 1 for RV32, extension bit I set
`define CSR_MISA 32'h4000_0100

// Direct mode, fixed handler base
`define CSR_MTVEC 32'h0000_0100

// No lower privilege modes, so no counters are delegated
`define CSR_MCOUNTEREN 32'h0000_0000

// Writable bits of mie and mip (MSI, MTI, MEI)
`define CSR_IRQ_MASK 32'h0000_0888

// IALIGN = 32, so mepc[1:0] is always zero
`define CSR_MEPC_MASK 32'hFFFF_FFFC

// Hard reset value of mcause
`define CSR_MCAUSE_RESET 32'h0000_0000

`endif

//--- src/csr_addr_pkg.sv
`default_nettype none

package csr_addr_pkg;

    // Machine-mode CSR addresses implemented by this core
    typedef enum logic [11:0] {
        // Machine information registers
        csr_mvendorid  = 12'hf11,
        csr_marchid    = 12'hf12,
        csr_mimpid     = 12'hf13,
        csr_mhartid    = 12'hf14,

        // Machine trap setup
        csr_mstatus    = 12'h300,
        csr_misa       = 12'h301,
        csr_mie        = 12'h304,
        csr_mtvec      = 12'h305,
        csr_mcounteren = 12'h306,

        // Machine trap handling
        csr_mscratch   = 12'h340,
        csr_mepc       = 12'h341,
        csr_mcause     = 12'h342,
        csr_mtval      = 12'h343,
        csr_mip        = 12'h344
    } csr_addr_e;

endpackage

`default_nettype wire

//--- src/csr_fields_pkg.sv
`default_nettype none

package csr_fields_pkg;

    // Privilege levels, only machine mode is implemented
    typedef enum logic [1:0] {
        priv_user    = 2'b00,
        priv_machine = 2'b11
    } priv_mode_e;

    // Field positions inside mstatus
    // MPP occupies mpp_lo and the bit above it
    typedef enum logic [4:0] {
        mstatus_mie    = 5'd3,
        mstatus_mpie   = 5'd7,
        mstatus_mpp_lo = 5'd11
    } mstatus_bit_e;

    // Interrupt bit positions
    // Same layout in mie and mip
    typedef enum logic [4:0] {
        irq_msi = 5'd3,
        irq_mti = 5'd7,
        irq_mei = 5'd11
    } irq_bit_e;

endpackage

`default_nettype wire

//--- src/mstatus_reg.sv
`default_nettype none

module mstatus_reg (
    input  logic        clk,
    input  logic        reset,
    input  logic        wr_csr_n,
    input  logic [11:0] csr_wr_addr,
    input  logic [31:0] csr_data_in,
    input  logic        is_mret,
    output logic [31:0] mstatus
);

    logic wr_mstatus;

    // Interrupt enable stack, the only stored fields
    logic mie_q;
    logic mpie_q;

    assign wr_mstatus = !wr_csr_n && (csr_wr_addr == csr_addr_pkg::csr_mstatus);

    // Software write wins over the MRET update
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            mie_q  <= 1'b0;
            mpie_q <= 1'b0;
        end
        else if (wr_mstatus)
        begin
            mie_q  <= csr_data_in[csr_fields_pkg::mstatus_mie];
            mpie_q <= csr_data_in[csr_fields_pkg::mstatus_mpie];
        end
        else if (is_mret)
        begin
            // Pop the enable stack
            mie_q  <= mpie_q;
            mpie_q <= 1'b1;
        end
    end

    // Reassemble the architectural view
    always_comb
    begin
        mstatus = 32'b0;
        mstatus[csr_fields_pkg::mstatus_mie]  = mie_q;
        mstatus[csr_fields_pkg::mstatus_mpie] = mpie_q;
        // M-only core, MPP is hardwired
        mstatus[csr_fields_pkg::mstatus_mpp_lo +: 2] = csr_fields_pkg::priv_machine;
    end

endmodule

`default_nettype wire

//--- src/interrupt_regs.sv
`default_nettype none

`include "csr_defines.svh"

module interrupt_regs (
    input  logic        clk,
    input  logic        reset,
    input  logic        wr_csr_n,
    input  logic [11:0] csr_wr_addr,
    input  logic [31:0] csr_data_in,
    output logic [31:0] mie,
    output logic [31:0] mip
);

    logic wr_en;

    assign wr_en = !wr_csr_n;

    // Interrupt enables
    // Only MSI, MTI and MEI are kept, the rest stays zero
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            mie <= 32'b0;
        end
        else if (wr_en && (csr_wr_addr == csr_addr_pkg::csr_mie))
        begin
            mie <= csr_data_in & `CSR_IRQ_MASK;
        end
    end

    // Pending bits
    // No interrupt pins here, so software is the only source
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            mip <= 32'b0;
        end
        else if (wr_en && (csr_wr_addr == csr_addr_pkg::csr_mip))
        begin
            mip <= csr_data_in & `CSR_IRQ_MASK;
        end
    end

endmodule

`default_nettype wire

//--- src/trap_handling_regs.sv
`default_nettype none

`include "csr_defines.svh"

module trap_handling_regs (
    input  logic        clk,
    input  logic        reset,
    input  logic        wr_csr_n,
    input  logic [11:0] csr_wr_addr,
    input  logic [31:0] csr_data_in,
    output logic [31:0] mscratch,
    output logic [31:0] mepc,
    output logic [31:0] mcause,
    output logic [31:0] mtval
);

    logic wr_en;
    logic wr_mscratch;
    logic wr_mepc;
    logic wr_mcause;
    logic wr_mtval;

    assign wr_en = !wr_csr_n;

    // Write enable per register
    always_comb
    begin
        wr_mscratch = 1'b0;
        wr_mepc     = 1'b0;
        wr_mcause   = 1'b0;
        wr_mtval    = 1'b0;
        case (csr_addr_pkg::csr_addr_e'(csr_wr_addr))
            csr_addr_pkg::csr_mscratch: wr_mscratch = wr_en;
            csr_addr_pkg::csr_mepc:     wr_mepc     = wr_en;
            csr_addr_pkg::csr_mcause:   wr_mcause   = wr_en;
            csr_addr_pkg::csr_mtval:    wr_mtval    = wr_en;
            default:                    ;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            mscratch <= 32'b0;
            mepc     <= 32'b0;
            mcause   <= `CSR_MCAUSE_RESET;
            mtval    <= 32'b0;
        end
        else
        begin
            if (wr_mscratch)
            begin
                mscratch <= csr_data_in;
            end
            // Return address is word aligned
            if (wr_mepc)
            begin
                mepc <= csr_data_in & `CSR_MEPC_MASK;
            end
            if (wr_mcause)
            begin
                mcause <= csr_data_in;
            end
            if (wr_mtval)
            begin
                mtval <= csr_data_in;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/csr_read_mux.sv
`default_nettype none

`include "csr_defines.svh"

module csr_read_mux (
    input  logic [11:0] csr_addr,
    input  logic        is_mret,
    input  logic [31:0] mstatus,
    input  logic [31:0] mie,
    input  logic [31:0] mip,
    input  logic [31:0] mscratch,
    input  logic [31:0] mepc,
    input  logic [31:0] mcause,
    input  logic [31:0] mtval,
    output logic [31:0] csr_out
);

    logic [31:0] csr_sel;

    // Address decode
    // Read-only registers are plain constants here
    always_comb
    begin
        case (csr_addr_pkg::csr_addr_e'(csr_addr))
            csr_addr_pkg::csr_mvendorid:  csr_sel = `CSR_MVENDORID;
            csr_addr_pkg::csr_marchid:    csr_sel = `CSR_MARCHID;
            csr_addr_pkg::csr_mimpid:     csr_sel = `CSR_MIMPID;
            csr_addr_pkg::csr_mhartid:    csr_sel = `CSR_MHARTID;

            csr_addr_pkg::csr_mstatus:    csr_sel = mstatus;
            csr_addr_pkg::csr_misa:       csr_sel = `CSR_MISA;
            csr_addr_pkg::csr_mie:        csr_sel = mie;
            csr_addr_pkg::csr_mtvec:      csr_sel = `CSR_MTVEC;
            csr_addr_pkg::csr_mcounteren: csr_sel = `CSR_MCOUNTEREN;

            csr_addr_pkg::csr_mscratch:   csr_sel = mscratch;
            csr_addr_pkg::csr_mepc:       csr_sel = mepc;
            csr_addr_pkg::csr_mcause:     csr_sel = mcause;
            csr_addr_pkg::csr_mtval:      csr_sel = mtval;
            csr_addr_pkg::csr_mip:        csr_sel = mip;

            // Unimplemented CSRs read as zero
            default:                      csr_sel = 32'b0;
        endcase
    end

    // During MRET the address field of the instruction does not name mepc,
    // so the return address is forced onto the port for the fetch redirect
    always_comb
    begin
        if (is_mret)
        begin
            csr_out = mepc;
        end
        else
        begin
            csr_out = csr_sel;
        end
    end

endmodule

`default_nettype wire

//--- src/csr_file.sv
`default_nettype none

module csr_file (
    input  logic        clk,
    input  logic        reset,

    // Read port
    input  logic [11:0] csr_addr,

    // Write port
    input  logic [11:0] csr_wr_addr,
    input  logic [31:0] csr_data_in,
    input  logic        wr_csr_n,

    input  logic        is_mret,

    output logic [31:0] csr_out
);

    logic [31:0] mstatus;
    logic [31:0] mie;
    logic [31:0] mip;
    logic [31:0] mscratch;
    logic [31:0] mepc;
    logic [31:0] mcause;
    logic [31:0] mtval;

    // Trap setup, writable part
    mstatus_reg i_mstatus_reg (
        .clk         (clk),
        .reset       (reset),
        .wr_csr_n    (wr_csr_n),
        .csr_wr_addr (csr_wr_addr),
        .csr_data_in (csr_data_in),
        .is_mret     (is_mret),
        .mstatus     (mstatus)
    );

    interrupt_regs i_interrupt_regs (
        .clk         (clk),
        .reset       (reset),
        .wr_csr_n    (wr_csr_n),
        .csr_wr_addr (csr_wr_addr),
        .csr_data_in (csr_data_in),
        .mie         (mie),
        .mip         (mip)
    );

    // Trap handling
    trap_handling_regs i_trap_handling_regs (
        .clk         (clk),
        .reset       (reset),
        .wr_csr_n    (wr_csr_n),
        .csr_wr_addr (csr_wr_addr),
        .csr_data_in (csr_data_in),
        .mscratch    (mscratch),
        .mepc        (mepc),
        .mcause      (mcause),
        .mtval       (mtval)
    );

    csr_read_mux i_csr_read_mux (
        .csr_addr (csr_addr),
        .is_mret  (is_mret),
        .mstatus  (mstatus),
        .mie      (mie),
        .mip      (mip),
        .mscratch (mscratch),
        .mepc     (mepc),
        .mcause   (mcause),
        .mtval    (mtval),
        .csr_out  (csr_out)
    );

endmodule

`default_nettype wire

//--- testbench/csr_file_asserts.sv
`default_nettype none

module csr_file_asserts (
    input logic        clk,
    input logic        reset,
    input logic        is_mret,
    input logic [31:0] mstatus,
    input logic [31:0] mepc,
    input logic [31:0] csr_out
);

    // Return address stays word aligned
    mepc_aligned: assert property (@(posedge clk) disable iff (reset) mepc[1:0] == 2'b00)
        else $error("mepc has nonzero low bits");

    // MPP hardwired to machine mode
    mpp_machine: assert property (@(posedge clk) mstatus[12:11] == 2'b11)
        else $error("mstatus MPP is not machine mode");

    // Enable stack cleared by reset
    mstatus_reset: assert property (@(posedge clk) reset |=> (mstatus == 32'h0000_1800))
        else $error("mstatus did not return to its reset value");

    mret_reads_mepc: assert property (@(posedge clk) disable iff (reset)
        is_mret |-> (csr_out == mepc))
        else $error("csr_out does not show mepc during MRET");

endmodule

bind csr_file csr_file_asserts i_csr_file_asserts (
    .clk     (clk),
    .reset   (reset),
    .is_mret (is_mret),
    .mstatus (mstatus),
    .mepc    (mepc),
    .csr_out (csr_out)
);

`default_nettype wire

//--- testbench/csr_file_tb.sv
`default_nettype none

module csr_file_tb;

    localparam int NUM_ROWS   = 32;
    localparam int NUM_RANDOM = 200;
    localparam int CLK_PERIOD = 4;

    // wr_csr_n, csr_wr_addr, csr_data_in, is_mret, csr_addr, expected csr_out
    localparam logic [89:0] ROWS [NUM_ROWS] = '{
        // Reset values and constants
        {1'b1, 12'h000, 32'h0000_0000, 1'b0, 12'hf11, 32'h0000_0000},
        {1'b1, 12'h000, 32'h0000_0000, 1'b0, 12'hf12, 32'h0000_0001},
        {1'b1, 12'h000, 32'h0000_0000, 1'b0, 12'hf13, 32'h0000_0000},
        {1'b1, 12'h000, 32'h0000_0000, 1'b0, 12'hf14, 32'h0000_0000},
        {1'b1, 12'h000, 32'h0000_0000, 1'b0, 12'h300, 32'h0000_1800},
        {1'b1, 12'h000, 32'h0000_0000, 1'b0, 12'h301, 32'h4000_0100},
        {1'b1, 12'h000, 32'h0000_0000, 1'b0, 12'h304, 32'h0000_0000},
        {1'b1, 12'h000, 32'h0000_0000, 1'b0, 12'h305, 32'h0000_0100},
        {1'b1, 12'h000, 32'h0000_0000, 1'b0, 12'h306, 32'h0000_0000},
        {1'b1, 12'h000, 32'h0000_0000, 1'b0, 12'h340, 32'h0000_0000},
        {1'b1, 12'h000, 32'h0000_0000, 1'b0, 12'h341, 32'h0000_0000},
        {1'b1, 12'h000, 32'h0000_0000, 1'b0, 12'h342, 32'h0000_0000},
        {1'b1, 12'h000, 32'h0000_0000, 1'b0, 12'h343, 32'h0000_0000},
        {1'b1, 12'h000, 32'h0000_0000, 1'b0, 12'h344, 32'h0000_0000},
        {1'b1, 12'h000, 32'h0000_0000, 1'b0, 12'h7c0, 32'h0000_0000},
        // All-ones writes, each read back one cycle later
        {1'b0, 12'h304, 32'hffff_ffff, 1'b0, 12'h304, 32'h0000_0000},
        {1'b0, 12'h344, 32'hffff_ffff, 1'b0, 12'h304, 32'h0000_0888},
        {1'b0, 12'h341, 32'hffff_ffff, 1'b0, 12'h344, 32'h0000_0888},
        {1'b0, 12'h340, 32'hffff_ffff, 1'b0, 12'h341, 32'hffff_fffc},
        {1'b0, 12'h342, 32'hffff_ffff, 1'b0, 12'h340, 32'hffff_ffff},
        {1'b0, 12'h343, 32'hffff_ffff, 1'b0, 12'h342, 32'hffff_ffff},
        {1'b0, 12'h301, 32'hffff_ffff, 1'b0, 12'h343, 32'hffff_ffff},
        {1'b0, 12'hf11, 32'hffff_ffff, 1'b0, 12'h301, 32'h4000_0100},
        {1'b0, 12'h7c0, 32'hffff_ffff, 1'b0, 12'hf11, 32'h0000_0000},
        {1'b1, 12'h000, 32'h0000_0000, 1'b0, 12'h7c0, 32'h0000_0000},
        // MRET with MPIE set, then MRET racing an mstatus write
        {1'b0, 12'h300, 32'h0000_0080, 1'b0, 12'h300, 32'h0000_1800},
        {1'b1, 12'h000, 32'h0000_0000, 1'b1, 12'h300, 32'hffff_fffc},
        {1'b1, 12'h000, 32'h0000_0000, 1'b0, 12'h300, 32'h0000_1888},
        {1'b0, 12'h300, 32'h0000_0000, 1'b1, 12'h300, 32'hffff_fffc},
        {1'b0, 12'h341, 32'h0000_1235, 1'b0, 12'h300, 32'h0000_1800},
        {1'b1, 12'h000, 32'h0000_0000, 1'b1, 12'h7c0, 32'h0000_1234},
        {1'b1, 12'h000, 32'h0000_0000, 1'b0, 12'h300, 32'h0000_1880}
    };

    // Implemented addresses plus two holes
    localparam logic [11:0] ADDR_POOL [16] = '{
        12'hf11, 12'hf12, 12'hf13, 12'hf14, 12'h300, 12'h301, 12'h304, 12'h305,
        12'h306, 12'h340, 12'h341, 12'h342, 12'h343, 12'h344, 12'h7c0, 12'h345
    };

    logic        clk;
    logic        reset;
    logic [11:0] csr_addr;
    logic [11:0] csr_wr_addr;
    logic [31:0] csr_data_in;
    logic        wr_csr_n;
    logic        is_mret;
    logic [31:0] csr_out;

    // Register mirror
    logic        st_mie;
    logic        st_mpie;
    logic [31:0] r_mie;
    logic [31:0] r_mip;
    logic [31:0] r_mscratch;
    logic [31:0] r_mepc;
    logic [31:0] r_mcause;
    logic [31:0] r_mtval;
    int          errors;

    csr_file i_csr_file (
        .clk         (clk),
        .reset       (reset),
        .csr_addr    (csr_addr),
        .csr_wr_addr (csr_wr_addr),
        .csr_data_in (csr_data_in),
        .wr_csr_n    (wr_csr_n),
        .is_mret     (is_mret),
        .csr_out     (csr_out)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected)
        begin
            errors++;
            $display("error %s expected %h got %h", name, expected, actual);
            $display("TEST FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic [31:0] model_read(input logic [11:0] addr, input logic mret);
        logic [31:0] value;
        case (addr)
            12'hf12: value = 32'h0000_0001;
            12'h300: value = 32'h0000_1800 | {24'b0, st_mpie, 3'b0, st_mie, 3'b0};
            12'h301: value = 32'h4000_0100;
            12'h304: value = r_mie;
            12'h305: value = 32'h0000_0100;
            12'h340: value = r_mscratch;
            12'h341: value = r_mepc;
            12'h342: value = r_mcause;
            12'h343: value = r_mtval;
            12'h344: value = r_mip;
            default: value = 32'h0000_0000;
        endcase
        // MRET puts the return address on the port
        if (mret)
        begin
            value = r_mepc;
        end
        return value;
    endfunction

    // State after the coming clock edge
    task automatic model_update(input logic wr_n, input logic [11:0] waddr,
                                input logic [31:0] wdata, input logic mret);
        if (!wr_n && waddr == 12'h300)
        begin
            st_mie  = wdata[3];
            st_mpie = wdata[7];
        end
        else if (mret)
        begin
            st_mie  = st_mpie;
            st_mpie = 1'b1;
        end
        if (!wr_n)
        begin
            case (waddr)
                12'h304: r_mie      = wdata & 32'h0000_0888;
                12'h344: r_mip      = wdata & 32'h0000_0888;
                12'h340: r_mscratch = wdata;
                12'h341: r_mepc     = wdata & 32'hffff_fffc;
                12'h342: r_mcause   = wdata;
                12'h343: r_mtval    = wdata;
                default: ;
            endcase
        end
    endtask

    initial
    begin
        #((NUM_ROWS + NUM_RANDOM + 20) * CLK_PERIOD);
        $display("timeout: the stimulus did not complete in the expected time");
        $display("TEST FAIL");
        $fatal(1, "watchdog expired");
    end

    initial
    begin
        logic        wr_n;
        logic [11:0] waddr;
        logic [31:0] wdata;
        logic        mret;
        logic [11:0] raddr;
        logic [31:0] expected;
        logic [31:0] rnd;

        void'($urandom(32'ha12e0dc7));
        errors      = 0;
        reset       = 1'b1;
        csr_addr    = 12'h000;
        csr_wr_addr = 12'h000;
        csr_data_in = 32'h0000_0000;
        wr_csr_n    = 1'b1;
        is_mret     = 1'b0;
        st_mie      = 1'b0;
        st_mpie     = 1'b0;
        r_mie       = 32'h0;
        r_mip       = 32'h0;
        r_mscratch  = 32'h0;
        r_mepc      = 32'h0;
        r_mcause    = 32'h0;
        r_mtval     = 32'h0;

        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;

        // Directed rows first, then random rows checked against the mirror
        for (int i = 0; i < NUM_ROWS + NUM_RANDOM; i++)
        begin
            if (i < NUM_ROWS)
            begin
                {wr_n, waddr, wdata, mret, raddr, expected} = ROWS[i];
            end
            else
            begin
                rnd      = $urandom();
                wr_n     = rnd[0];
                mret     = (rnd[3:1] == 3'b000);
                waddr    = ADDR_POOL[rnd[7:4]];
                raddr    = ADDR_POOL[rnd[11:8]];
                wdata    = $urandom();
                expected = model_read(raddr, mret);
            end
            wr_csr_n    = wr_n;
            csr_wr_addr = waddr;
            csr_data_in = wdata;
            is_mret     = mret;
            csr_addr    = raddr;
            #2;
            check_value("csr_out", expected, csr_out);
            model_update(wr_n, waddr, wdata, mret);
            @(posedge clk);
            #1;
        end

        wr_csr_n = 1'b1;
        is_mret  = 1'b0;

        if (errors == 0)
        begin
            $display("TEST PASS");
        end
        else
        begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+src
src/csr_addr_pkg.sv
src/csr_fields_pkg.sv
src/mstatus_reg.sv
src/interrupt_regs.sv
src/trap_handling_regs.sv
src/csr_read_mux.sv
src/csr_file.sv
testbench/csr_file_asserts.sv
testbench/csr_file_tb.sv

//--- run.sh
#!/bin/sh
# Compile and run the CSR file testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module csr_file_tb \
        -f files.f --Mdir obj_dir -o csr_file_sim; then
    echo "verilator build failed"
    exit 1
fi

if ! ./obj_dir/csr_file_sim > sim.log 2>&1; then
    cat sim.log
    echo "simulation exited with an error status"
    exit 1
fi

cat sim.log

if grep -q "^TEST PASS$" sim.log; then
    exit 0
fi

echo "pass message not found in sim.log"
exit 1
